/* hdl/snn_pkg.sv */
// widths, neuron constants, load mode codes and the load word union
package snn_pkg;

    // fixed-point and lane widths
    localparam int DATA_WIDTH = 16;
    localparam int LANES      = 5;
    localparam int ACC_WIDTH  = 24;
    localparam int REF_WIDTH  = 2;

    // leaky integrate-and-fire constants
    localparam logic signed [DATA_WIDTH-1:0] V_THRESHOLD = 16'sd4096;
    localparam int LEAK_SHIFT        = 3;
    localparam int REFRACTORY_PERIOD = 2;

    // initial-load modes, codes 5 to 15 write nothing
    localparam logic [3:0] MODE_NONE       = 4'd0;
    localparam logic [3:0] MODE_PARAM      = 4'd1;
    localparam logic [3:0] MODE_REFRACTORY = 4'd2;
    localparam logic [3:0] MODE_VOLTAGE    = 4'd3;
    localparam logic [3:0] MODE_WEIGHT     = 4'd4;

    // one 80-bit load word, read through the view the mode selects
    typedef union packed {
        // lane 0 sits in the low bits
        logic [LANES-1:0][DATA_WIDTH-1:0] weight;
        struct packed {
            logic [47:0]           pad;
            logic [DATA_WIDTH-1:0] bias;
            logic [DATA_WIDTH-1:0] encoder;
        } param;
        // voltage, or refractory count in the low bits
        struct packed {
            logic [63:0]           pad;
            logic [DATA_WIDTH-1:0] value;
        } scalar;
    } load_word_u;

endpackage

/* hdl/core_control.sv */
// idle/initial/compute/done state machine with sweep launch and output valid pulse
`timescale 1ns/10ps

module core_control import snn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_snn_compute,
    input  logic [3:0] sram_initial_mode,
    input  logic       sweep_done,
    output logic       load_allowed,
    output logic       sweep_start,
    output logic       snn_output_valid
);

    // one-hot states
    localparam logic [3:0] IDLE    = 4'b0001;
    localparam logic [3:0] INITIAL = 4'b0010;
    localparam logic [3:0] COMPUTE = 4'b0100;
    localparam logic [3:0] DONE    = 4'b1000;

    logic [3:0] state;
    logic [3:0] next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state            <= IDLE;
            snn_output_valid <= 1'b0;
        end else begin
            state            <= next_state;
            snn_output_valid <= (state == DONE);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // start wins over a pending load mode
                if (start_snn_compute) begin
                    next_state = COMPUTE;
                end else if (sram_initial_mode != MODE_NONE) begin
                    next_state = INITIAL;
                end
            end
            INITIAL: begin
                if (sram_initial_mode == MODE_NONE) begin
                    next_state = IDLE;
                end
            end
            COMPUTE: begin
                if (sweep_done) begin
                    next_state = DONE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign load_allowed = (state == IDLE) || (state == INITIAL);
    // accepted strobe, seen by scheduler and decoder on the edge into compute
    assign sweep_start  = (state == IDLE) && start_snn_compute;

    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst) snn_output_valid |=> !snn_output_valid
    );

endmodule

/* hdl/neuron_scheduler.sv */
// neuron address sweep feeding a read stage and a write-back stage
`timescale 1ns/10ps

module neuron_scheduler #(
    parameter int NEURON_NUM = 1024,
    localparam int ADDR_WIDTH = $clog2(NEURON_NUM)
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sweep_start,
    output logic                  read_en,
    output logic [ADDR_WIDTH-1:0] read_addr,
    output logic                  write_en,
    output logic [ADDR_WIDTH-1:0] write_addr,
    output logic                  accum_en,
    output logic                  sweep_done
);

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(NEURON_NUM - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            read_en    <= 1'b0;
            read_addr  <= '0;
            write_en   <= 1'b0;
            write_addr <= '0;
            sweep_done <= 1'b0;
        end else begin
            // stage one: issue one address per cycle
            if (sweep_start) begin
                read_en   <= 1'b1;
                read_addr <= '0;
            end else if (read_en) begin
                if (read_addr == LAST_ADDR) begin
                    read_en <= 1'b0;
                end else begin
                    read_addr <= read_addr + 1'b1;
                end
            end
            // stage two: write back while the read data is on the bus
            write_en   <= read_en;
            write_addr <= read_addr;
            sweep_done <= write_en && (write_addr == LAST_ADDR);
        end
    end

    // weights on the bus belong to a live neuron in the write-back stage
    assign accum_en = write_en;

    a_addr_range: assert property (
        @(posedge clk) disable iff (!rst) read_en |-> (read_addr < NEURON_NUM)
    );

endmodule

/* hdl/neuron_memory.sv */
// neuron state arrays with host load writes, compute write-back and synchronous read
`timescale 1ns/10ps

module neuron_memory import snn_pkg::*; #(
    parameter int NEURON_NUM = 1024,
    localparam int ADDR_WIDTH = $clog2(NEURON_NUM)
) (
    input  logic                              clk,
    input  logic [3:0]                        sram_initial_mode,
    input  logic                              load_allowed,
    input  load_word_u                        input_value_snn,
    input  logic [ADDR_WIDTH-1:0]             input_address_snn,
    input  logic                              read_en,
    input  logic [ADDR_WIDTH-1:0]             read_addr,
    input  logic                              write_en,
    input  logic [ADDR_WIDTH-1:0]             write_addr,
    input  logic signed [DATA_WIDTH-1:0]      voltage_new,
    input  logic [REF_WIDTH-1:0]              refractory_new,
    output logic signed [DATA_WIDTH-1:0]      bias,
    output logic signed [DATA_WIDTH-1:0]      encoder,
    output logic signed [DATA_WIDTH-1:0]      voltage_old,
    output logic [REF_WIDTH-1:0]              refractory_old,
    output logic [LANES-1:0][DATA_WIDTH-1:0]  weights
);

    // bias in the upper half, encoder in the lower half
    logic [2*DATA_WIDTH-1:0]          param_mem   [NEURON_NUM];
    logic [DATA_WIDTH-1:0]            voltage_mem [NEURON_NUM];
    logic [REF_WIDTH-1:0]             ref_mem     [NEURON_NUM];
    logic [LANES-1:0][DATA_WIDTH-1:0] weight_mem  [NEURON_NUM];

    logic [2*DATA_WIDTH-1:0] param_q;
    logic load_param;
    logic load_ref;
    logic load_voltage;
    logic load_weight;

    // mode decode, unknown codes enable nothing
    assign load_param   = load_allowed && (sram_initial_mode == MODE_PARAM);
    assign load_ref     = load_allowed && (sram_initial_mode == MODE_REFRACTORY);
    assign load_voltage = load_allowed && (sram_initial_mode == MODE_VOLTAGE);
    assign load_weight  = load_allowed && (sram_initial_mode == MODE_WEIGHT);

    always_ff @(posedge clk) begin
        if (load_param) begin
            param_mem[input_address_snn] <= {input_value_snn.param.bias,
                                             input_value_snn.param.encoder};
        end
        if (load_weight) begin
            weight_mem[input_address_snn] <= input_value_snn.weight;
        end
        // write-back only runs in compute, loads only outside it
        if (write_en) begin
            voltage_mem[write_addr] <= voltage_new;
            ref_mem[write_addr]     <= refractory_new;
        end else begin
            if (load_voltage) begin
                voltage_mem[input_address_snn] <= input_value_snn.scalar.value;
            end
            if (load_ref) begin
                ref_mem[input_address_snn] <= input_value_snn.scalar.value[REF_WIDTH-1:0];
            end
        end
    end

    // read data appears one cycle after read_en
    always_ff @(posedge clk) begin
        if (read_en) begin
            param_q        <= param_mem[read_addr];
            voltage_old    <= voltage_mem[read_addr];
            refractory_old <= ref_mem[read_addr];
            weights        <= weight_mem[read_addr];
        end
    end

    assign bias    = param_q[2*DATA_WIDTH-1:DATA_WIDTH];
    assign encoder = param_q[DATA_WIDTH-1:0];

endmodule

/* hdl/lif_neuron.sv */
// combinational leaky integrate-and-fire update with refractory countdown
`timescale 1ns/10ps

module lif_neuron import snn_pkg::*; (
    input  logic signed [DATA_WIDTH-1:0] bias,
    input  logic signed [DATA_WIDTH-1:0] encoder,
    input  logic signed [DATA_WIDTH-1:0] voltage_old,
    input  logic [REF_WIDTH-1:0]         refractory_old,
    output logic signed [DATA_WIDTH-1:0] voltage_new,
    output logic [REF_WIDTH-1:0]         refractory_new,
    output logic                         spike
);

    logic signed [DATA_WIDTH-1:0] current;
    logic signed [DATA_WIDTH-1:0] leak;
    logic signed [DATA_WIDTH-1:0] v_next;

    // all sums wrap at 16 bits
    assign current = bias + encoder;
    assign leak    = voltage_old >>> LEAK_SHIFT;
    assign v_next  = voltage_old - leak + current;

    always_comb begin
        if (refractory_old != '0) begin
            // resting, voltage held at zero
            voltage_new    = '0;
            refractory_new = refractory_old - 1'b1;
            spike          = 1'b0;
        end else if (v_next >= V_THRESHOLD) begin
            voltage_new    = '0;
            refractory_new = REF_WIDTH'(REFRACTORY_PERIOD);
            spike          = 1'b1;
        end else begin
            voltage_new    = v_next;
            refractory_new = '0;
            spike          = 1'b0;
        end
    end

    // a host-loaded count of 3 must still drain below the period
    always_comb begin
        a_ref_bound: assert (refractory_new <= REFRACTORY_PERIOD);
    end

endmodule

/* hdl/decoder_accumulator.sv */
// five decoder accumulators summing the weights of spiking neurons
`timescale 1ns/10ps

module decoder_accumulator import snn_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sweep_start,
    input  logic                              accum_en,
    input  logic                              spike,
    input  logic [LANES-1:0][DATA_WIDTH-1:0]  weights,
    output logic [LANES-1:0][ACC_WIDTH-1:0]   u_adapt
);

    logic [LANES-1:0][ACC_WIDTH-1:0] weight_ext;

    // sign-extend each lane to accumulator width
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            weight_ext[i] = {{(ACC_WIDTH-DATA_WIDTH){weights[i][DATA_WIDTH-1]}}, weights[i]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            u_adapt <= '0;
        end else if (sweep_start) begin
            u_adapt <= '0;
        end else if (accum_en && spike) begin
            // sums wrap modulo 2^ACC_WIDTH
            for (int i = 0; i < LANES; i++) begin
                u_adapt[i] <= u_adapt[i] + weight_ext[i];
            end
        end
    end

endmodule

/* hdl/snn_core.sv */
// spiking neuron core top level joining control, scheduler, memory, neuron and decoder
`timescale 1ns/10ps

module snn_core import snn_pkg::*; #(
    parameter int NEURON_NUM = 1024,
    localparam int ADDR_WIDTH = $clog2(NEURON_NUM)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_snn_compute,
    input  logic [3:0]                        sram_initial_mode,
    input  load_word_u                        input_value_snn,
    input  logic [ADDR_WIDTH-1:0]             input_address_snn,
    output logic                              snn_output_valid,
    output logic [LANES-1:0][ACC_WIDTH-1:0]   u_adapt
);

    logic                              load_allowed;
    logic                              sweep_start;
    logic                              sweep_done;
    logic                              read_en;
    logic [ADDR_WIDTH-1:0]             read_addr;
    logic                              write_en;
    logic [ADDR_WIDTH-1:0]             write_addr;
    logic                              accum_en;
    logic signed [DATA_WIDTH-1:0]      bias;
    logic signed [DATA_WIDTH-1:0]      encoder;
    logic signed [DATA_WIDTH-1:0]      voltage_old;
    logic signed [DATA_WIDTH-1:0]      voltage_new;
    logic [REF_WIDTH-1:0]              refractory_old;
    logic [REF_WIDTH-1:0]              refractory_new;
    logic                              spike;
    logic [LANES-1:0][DATA_WIDTH-1:0]  weights;

    core_control u_control (
        .clk               (clk),
        .rst               (rst),
        .start_snn_compute (start_snn_compute),
        .sram_initial_mode (sram_initial_mode),
        .sweep_done        (sweep_done),
        .load_allowed      (load_allowed),
        .sweep_start       (sweep_start),
        .snn_output_valid  (snn_output_valid)
    );

    neuron_scheduler #(.NEURON_NUM(NEURON_NUM)) u_scheduler (
        .clk         (clk),
        .rst         (rst),
        .sweep_start (sweep_start),
        .read_en     (read_en),
        .read_addr   (read_addr),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .accum_en    (accum_en),
        .sweep_done  (sweep_done)
    );

    neuron_memory #(.NEURON_NUM(NEURON_NUM)) u_memory (
        .clk               (clk),
        .sram_initial_mode (sram_initial_mode),
        .load_allowed      (load_allowed),
        .input_value_snn   (input_value_snn),
        .input_address_snn (input_address_snn),
        .read_en           (read_en),
        .read_addr         (read_addr),
        .write_en          (write_en),
        .write_addr        (write_addr),
        .voltage_new       (voltage_new),
        .refractory_new    (refractory_new),
        .bias              (bias),
        .encoder           (encoder),
        .voltage_old       (voltage_old),
        .refractory_old    (refractory_old),
        .weights           (weights)
    );

    lif_neuron u_lif (
        .bias           (bias),
        .encoder        (encoder),
        .voltage_old    (voltage_old),
        .refractory_old (refractory_old),
        .voltage_new    (voltage_new),
        .refractory_new (refractory_new),
        .spike          (spike)
    );

    decoder_accumulator u_decoder (
        .clk         (clk),
        .rst         (rst),
        .sweep_start (sweep_start),
        .accum_en    (accum_en),
        .spike       (spike),
        .weights     (weights),
        .u_adapt     (u_adapt)
    );

endmodule

/* dv/snn_core_tb.sv */
// testbench for the spiking neuron core with stimulus table, reference model and watchdog
`timescale 1ns/10ps

module snn_core_tb import snn_pkg::*; ();

    localparam int NEURON_NUM = 16;
    localparam int ADDR_WIDTH = $clog2(NEURON_NUM);
    localparam logic [1:0] STYLE_RANDOM = 2'd0;
    localparam logic [1:0] STYLE_FIRE   = 2'd1;
    localparam logic [1:0] STYLE_JUNK   = 2'd2;

    typedef struct packed {
        logic [7:0]  touch;
        logic [7:0]  sweeps;
        logic [1:0]  style;
        logic [15:0] pulses;
        logic [31:0] seed;
    } row_t;

    // touch: neurons loaded, pulses: valid pulses the row must add
    localparam int ROWS_N = 5;
    localparam row_t ROWS [ROWS_N] = '{
        '{touch: 8'd16, sweeps: 8'd1, style: STYLE_RANDOM, pulses: 16'd1, seed: 32'h1f2e3d4c},
        '{touch: 8'd4,  sweeps: 8'd3, style: STYLE_RANDOM, pulses: 16'd3, seed: 32'h0badf00d},
        '{touch: 8'd6,  sweeps: 8'd1, style: STYLE_JUNK,   pulses: 16'd1, seed: 32'h5a5a1234},
        '{touch: 8'd16, sweeps: 8'd1, style: STYLE_FIRE,   pulses: 16'd1, seed: 32'h7e3c9b01},
        '{touch: 8'd0,  sweeps: 8'd3, style: STYLE_RANDOM, pulses: 16'd3, seed: 32'h00c0ffee}
    };

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            start_snn_compute;
    logic [3:0]                      sram_initial_mode;
    load_word_u                      input_value_snn;
    logic [ADDR_WIDTH-1:0]           input_address_snn;
    logic                            snn_output_valid;
    logic [LANES-1:0][ACC_WIDTH-1:0] u_adapt;

    // reference copy of the neuron state
    logic signed [DATA_WIDTH-1:0] bias_m [NEURON_NUM];
    logic signed [DATA_WIDTH-1:0] enc_m  [NEURON_NUM];
    logic signed [DATA_WIDTH-1:0] volt_m [NEURON_NUM];
    logic [REF_WIDTH-1:0]         ref_m  [NEURON_NUM];
    logic signed [DATA_WIDTH-1:0] w_m    [NEURON_NUM][LANES];
    logic [31:0]                  rng;
    logic [15:0]                  valid_seen = '0;

    snn_core #(.NEURON_NUM(NEURON_NUM)) dut0 (
        .clk               (clk),
        .rst               (rst),
        .start_snn_compute (start_snn_compute),
        .sram_initial_mode (sram_initial_mode),
        .input_value_snn   (input_value_snn),
        .input_address_snn (input_address_snn),
        .snn_output_valid  (snn_output_valid),
        .u_adapt           (u_adapt)
    );

    always #20 clk = ~clk;

    // sees the pulse level of the cycle that just ended
    always @(posedge clk) begin
        if (rst && snn_output_valid) begin
            valid_seen <= valid_seen + 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int budget_cycles();
        int total;
        total = 200;
        for (int r = 0; r < ROWS_N; r++) begin
            total += int'(ROWS[r].sweeps) * (NEURON_NUM + 20) + 4 * int'(ROWS[r].touch);
            total += 2 * NEURON_NUM + 20;
        end
        return total;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_lanes(input logic [LANES-1:0][ACC_WIDTH-1:0] got,
                               input logic [LANES-1:0][ACC_WIDTH-1:0] want, input string what);
        for (int k = 0; k < LANES; k++) begin
            if (got[k] !== want[k]) begin
                report_failure($sformatf("mismatch at %0t: %s lane %0d got %h expected %h",
                                         $time, what, k, got[k], want[k]));
            end
        end
    endtask

    task automatic check_valid(input logic [15:0] got, input logic [15:0] want, input string what);
        if (got !== want) begin
            report_failure($sformatf("mismatch at %0t: %s saw %0d valid pulses, expected %0d",
                                     $time, what, got, want));
        end
    endtask

    task automatic put_word(input logic [3:0] mode, input logic [ADDR_WIDTH-1:0] addr,
                            input load_word_u word);
        @(posedge clk);
        sram_initial_mode <= mode;
        input_address_snn <= addr;
        input_value_snn   <= word;
    endtask

    // random state, or a sure spike with negative weights
    task automatic load_neuron(input logic [ADDR_WIDTH-1:0] addr, input logic all_fire);
        load_word_u w;
        if (all_fire) begin
            bias_m[addr] = 16'sd2048;
            enc_m[addr]  = 16'sd2048;
            volt_m[addr] = 16'sd4096;
            ref_m[addr]  = '0;
        end else begin
            rng = xorshift(rng);
            bias_m[addr] = $signed(rng[15:0]) >>> 4;
            enc_m[addr]  = $signed(rng[31:16]) >>> 4;
            rng = xorshift(rng);
            volt_m[addr] = $signed(rng[15:0]) >>> 2;
            ref_m[addr]  = rng[17:16];
        end
        w = '0;
        for (int k = 0; k < LANES; k++) begin
            rng = xorshift(rng);
            w_m[addr][k] = all_fire ? {1'b1, rng[14:0]} : rng[15:0];
            w.weight[k]  = w_m[addr][k];
        end
        put_word(MODE_WEIGHT, addr, w);
        w = '0;
        w.param.bias    = bias_m[addr];
        w.param.encoder = enc_m[addr];
        put_word(MODE_PARAM, addr, w);
        w = '0;
        w.scalar.value = volt_m[addr];
        put_word(MODE_VOLTAGE, addr, w);
        w = '0;
        w.scalar.value = {{(DATA_WIDTH-REF_WIDTH){1'b0}}, ref_m[addr]};
        put_word(MODE_REFRACTORY, addr, w);
    endtask

    task automatic predict_sweep(output logic [LANES-1:0][ACC_WIDTH-1:0] want);
        logic signed [DATA_WIDTH-1:0] cur;
        logic signed [DATA_WIDTH-1:0] v;
        want = '0;
        for (int i = 0; i < NEURON_NUM; i++) begin
            cur = bias_m[i] + enc_m[i];
            v   = volt_m[i] - (volt_m[i] >>> LEAK_SHIFT) + cur;
            if (ref_m[i] != '0) begin
                ref_m[i]  = ref_m[i] - 1'b1;
                volt_m[i] = '0;
            end else if (v >= V_THRESHOLD) begin
                volt_m[i] = '0;
                ref_m[i]  = REF_WIDTH'(REFRACTORY_PERIOD);
                for (int k = 0; k < LANES; k++) begin
                    want[k] = want[k] + ACC_WIDTH'(w_m[i][k]);
                end
            end else begin
                volt_m[i] = v;
            end
        end
    endtask

    task automatic strobe_start();
        @(posedge clk);
        start_snn_compute <= 1'b1;
        @(posedge clk);
        start_snn_compute <= 1'b0;
    endtask

    initial begin
        repeat (budget_cycles()) @(posedge clk);
        report_failure("timeout: the core never finished within the cycle budget");
    end

    initial begin
        logic [LANES-1:0][ACC_WIDTH-1:0] expected;
        logic [15:0]                     pulses;
        load_word_u                      junk;
        rst               = 1'b0;
        start_snn_compute = 1'b0;
        sram_initial_mode = MODE_NONE;
        input_value_snn   = '0;
        input_address_snn = '0;
        rng               = 32'hc4cb;
        pulses            = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        for (int r = 0; r < ROWS_N; r++) begin
            rng = xorshift(rng ^ ROWS[r].seed);
            if (ROWS[r].style == STYLE_JUNK) begin
                // codes 5 to 15 must leave every array untouched
                for (int j = 0; j < int'(ROWS[r].touch); j++) begin
                    rng  = xorshift(rng);
                    junk = {rng, xorshift(rng), rng[15:0]};
                    put_word(4'(5 + rng % 11), rng[ADDR_WIDTH-1:0], junk);
                end
                // core sits in the initial state, so this start is dropped
                strobe_start();
                repeat (NEURON_NUM + 10) @(posedge clk);
                @(negedge clk);
                check_valid(valid_seen, pulses, "start in initial state");
            end else begin
                for (int j = 0; j < int'(ROWS[r].touch); j++) begin
                    load_neuron(ADDR_WIDTH'(j), ROWS[r].style == STYLE_FIRE);
                end
            end
            @(posedge clk);
            sram_initial_mode <= MODE_NONE;
            @(posedge clk);
            for (int s = 0; s < int'(ROWS[r].sweeps); s++) begin
                strobe_start();
                do @(negedge clk); while (!snn_output_valid);
                predict_sweep(expected);
                check_lanes(u_adapt, expected, $sformatf("row %0d sweep %0d", r, s));
            end
            @(negedge clk);
            pulses = pulses + ROWS[r].pulses;
            check_valid(valid_seen, pulses, $sformatf("row %0d", r));
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* all.f */
hdl/snn_pkg.sv
hdl/core_control.sv
hdl/neuron_scheduler.sv
hdl/neuron_memory.sv
hdl/lif_neuron.sv
hdl/decoder_accumulator.sv
hdl/snn_core.sv
dv/snn_core_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the spiking neuron core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module snn_core_tb -o snn_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile step failed with status $status"
    exit $status
fi

./obj_dir/snn_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
